// ==== filelist.f ====
+incdir+hdl
hdl/arcade_ctrl_pkg.sv
hdl/rotary_tracker.sv
hdl/control_mapper.sv
hdl/ctrl_regs_axil.sv
hdl/arcade_ctrl_top.sv
tests/tb_clock_gen.sv
tests/arcade_ctrl_sva.sv
tests/arcade_ctrl_tb.sv

// ==== hdl/arcade_ctrl_params.svh ====
//==========================================================
// Shared constants for the player-control front end
// Register offsets, board code and rotary reset position
// Include in any module that needs one of these values
//==========================================================

`ifndef ARCADE_CTRL_PARAMS_SVH
`define ARCADE_CTRL_PARAMS_SVH

// AXI4-Lite address width in bits
`define CTRL_ADDR_W 4

// Register byte offsets
`define REG_CONFIG 4'h0
`define REG_DIP    4'h4
`define REG_WORDS  4'h8
`define REG_ROTARY 4'hC

// Board code of the gold-medal board
`define PCB_GOLDMEDL 4'd7

// Rotary ring position after reset
`define ROTARY_RESET 12'h001

`endif

// ==== hdl/arcade_ctrl_pkg.sv ====
//==========================================================
// Types shared by the player-control front end
// Raw inputs, host configuration and the CPU-visible words
//==========================================================

`default_nettype none

package arcade_ctrl_pkg;

	// Raw active-high levels of one player
	typedef struct packed {
		logic       start;
		logic       coin;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
		logic [2:0] fire;
		logic       rotary_cw_btn;
		logic       rotary_ccw_btn;
		logic       alt_up;
		logic       alt_down;
		logic       alt_left;
		logic       alt_right;
	} player_raw_t;

	typedef struct packed {
		logic test;
		logic service;
	} service_t;

	// Host-written board configuration
	typedef struct packed {
		logic [3:0] pcb;
		logic       tate;
		logic [7:0] brd;
		logic [7:0] dsw1;
		logic [7:0] dsw2;
	} ctrl_cfg_t;

	// Words seen by the game CPUs, p1 in the low byte
	typedef struct packed {
		logic [7:0] dsw_sp85;
		logic [7:0] dsw_m68k;
		logic [7:0] p2;
		logic [7:0] p1;
	} ctrl_words_t;

	// One player byte, standard and gold-medal decodings
	typedef union packed {
		struct packed {
			logic       start;
			logic [2:0] fire;
			logic       right;
			logic       left;
			logic       down;
			logic       up;
		} std;
		struct packed {
			logic start_a;
			logic start_b;
			logic b_fire1;
			logic a_fire1;
			logic b_fire2;
			logic b_fire0;
			logic a_fire2;
			logic a_fire0;
		} gm;
	} player_word_u;

	typedef logic [11:0] rotary_pos_t;

endpackage

`default_nettype wire

// ==== hdl/arcade_ctrl_top.sv ====
//==========================================================
// Player-control front end top level
// Two rotary trackers, the control mapper and the
// AXI4-Lite register slave used by the host
//==========================================================

`default_nettype none

`include "arcade_ctrl_params.svh"

module arcade_ctrl_top import arcade_ctrl_pkg::*; (
	input  logic                    clk_72,
	input  logic                    reset,
	input  player_raw_t             player1,
	input  player_raw_t             player2,
	input  service_t                service,
	input  logic [`CTRL_ADDR_W-1:0] awaddr,
	input  logic                    awvalid,
	output logic                    awready,
	input  logic [31:0]             wdata,
	input  logic [3:0]              wstrb,
	input  logic                    wvalid,
	output logic                    wready,
	output logic [1:0]              bresp,
	output logic                    bvalid,
	input  logic                    bready,
	input  logic [`CTRL_ADDR_W-1:0] araddr,
	input  logic                    arvalid,
	output logic                    arready,
	output logic [31:0]             rdata,
	output logic [1:0]              rresp,
	output logic                    rvalid,
	input  logic                    rready
);

	logic        rot1_cw;
	logic        rot1_ccw;
	logic        rot2_cw;
	logic        rot2_ccw;
	rotary_pos_t rotary1;
	rotary_pos_t rotary2;
	ctrl_cfg_t   cfg;
	ctrl_words_t words;

	// Rotary button or second stick turns the ring
	assign rot1_cw  = player1.rotary_cw_btn | player1.alt_right | player1.alt_up;
	assign rot1_ccw = player1.rotary_ccw_btn | player1.alt_left | player1.alt_down;
	assign rot2_cw  = player2.rotary_cw_btn | player2.alt_right | player2.alt_up;
	assign rot2_ccw = player2.rotary_ccw_btn | player2.alt_left | player2.alt_down;

	rotary_tracker rot1_i (
		.clk_72   (clk_72),
		.reset    (reset),
		.cw       (rot1_cw),
		.ccw      (rot1_ccw),
		.position (rotary1)
	);

	rotary_tracker rot2_i (
		.clk_72   (clk_72),
		.reset    (reset),
		.cw       (rot2_cw),
		.ccw      (rot2_ccw),
		.position (rotary2)
	);

	control_mapper mapper_i (
		.clk_72  (clk_72),
		.reset   (reset),
		.player1 (player1),
		.player2 (player2),
		.service (service),
		.cfg     (cfg),
		.words   (words)
	);

	ctrl_regs_axil regs_i (
		.clk_72  (clk_72),
		.reset   (reset),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.cfg     (cfg),
		.words   (words),
		.rotary1 (rotary1),
		.rotary2 (rotary2)
	);

endmodule

`default_nettype wire

// ==== hdl/control_mapper.sv ====
//==========================================================
// Maps raw button levels and DIP banks to the CPU words
// Standard boards are active low, gold-medal is active high
// Outputs are registered, one cycle behind their inputs
//==========================================================

`default_nettype none

`include "arcade_ctrl_params.svh"

module control_mapper import arcade_ctrl_pkg::*; (
	input  logic        clk_72,
	input  logic        reset,
	input  player_raw_t player1,
	input  player_raw_t player2,
	input  service_t    service,
	input  ctrl_cfg_t   cfg,
	output ctrl_words_t words
);

	player_word_u std1;
	player_word_u std2;
	player_word_u gold;
	logic [7:0]   dsw_std;
	ctrl_words_t  words_next;

	function automatic player_word_u std_view(input player_raw_t p);
		player_word_u w;
		w.std.start = p.start;
		w.std.fire  = p.fire;
		w.std.right = p.right;
		w.std.left  = p.left;
		w.std.down  = p.down;
		w.std.up    = p.up;
		return w;
	endfunction

	always_comb begin
		std1 = std_view(player1);
		std2 = std_view(player2);

		// Both players share one byte on the gold-medal board
		gold.gm.start_a = player1.start;
		gold.gm.start_b = player2.start;
		gold.gm.b_fire1 = player2.fire[1];
		gold.gm.a_fire1 = player1.fire[1];
		gold.gm.b_fire2 = player2.fire[2];
		gold.gm.b_fire0 = player2.fire[0];
		gold.gm.a_fire2 = player1.fire[2];
		gold.gm.a_fire0 = player1.fire[0];

		// Test and service sit in the two low DIP bits, active low
		dsw_std = {cfg.dsw1[7:2], ~service.test, ~service.service};

		words_next.dsw_sp85 = cfg.dsw2;
		if (cfg.pcb == `PCB_GOLDMEDL) begin
			words_next.p1       = gold;
			words_next.p2       = 8'h00;
			words_next.dsw_m68k = ~dsw_std;
		end else begin
			words_next.p1       = ~std1;
			words_next.p2       = ~std2;
			words_next.dsw_m68k = dsw_std;
		end
	end

	always_ff @(posedge clk_72) begin
		if (reset)
			words <= '0;
		else
			words <= words_next;
	end

endmodule

`default_nettype wire

// ==== hdl/ctrl_regs_axil.sv ====
//==========================================================
// AXI4-Lite slave for the control front end
// Holds board configuration and DIP banks, and returns
// the mapped CPU words and both rotary positions
//==========================================================

`default_nettype none

`include "arcade_ctrl_params.svh"

module ctrl_regs_axil import arcade_ctrl_pkg::*; (
	input  logic                    clk_72,
	input  logic                    reset,
	input  logic [`CTRL_ADDR_W-1:0] awaddr,
	input  logic                    awvalid,
	output logic                    awready,
	input  logic [31:0]             wdata,
	input  logic [3:0]              wstrb,
	input  logic                    wvalid,
	output logic                    wready,
	output logic [1:0]              bresp,
	output logic                    bvalid,
	input  logic                    bready,
	input  logic [`CTRL_ADDR_W-1:0] araddr,
	input  logic                    arvalid,
	output logic                    arready,
	output logic [31:0]             rdata,
	output logic [1:0]              rresp,
	output logic                    rvalid,
	input  logic                    rready,
	output ctrl_cfg_t               cfg,
	input  ctrl_words_t             words,
	input  rotary_pos_t             rotary1,
	input  rotary_pos_t             rotary2
);

	logic        wr_hs;
	logic        rd_hs;
	logic [31:0] rd_value;

	// Only OKAY responses
	assign bresp = 2'b00;
	assign rresp = 2'b00;

	assign wr_hs = awvalid & awready & wvalid & wready;
	assign rd_hs = arvalid & arready;

	//==========================================================
	// Write channel
	//==========================================================
	always_ff @(posedge clk_72) begin
		if (reset) begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			cfg     <= '0;
		end else begin
			// Address and data are taken together, one beat at a time
			awready <= awvalid & wvalid & ~bvalid & ~awready;
			wready  <= awvalid & wvalid & ~bvalid & ~awready;
			if (wr_hs)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;

			if (wr_hs && awaddr == `REG_CONFIG) begin
				if (wstrb[0]) begin
					cfg.pcb  <= wdata[3:0];
					cfg.tate <= wdata[7];
				end
				if (wstrb[1])
					cfg.brd <= wdata[15:8];
			end
			if (wr_hs && awaddr == `REG_DIP) begin
				if (wstrb[0])
					cfg.dsw1 <= wdata[7:0];
				if (wstrb[1])
					cfg.dsw2 <= wdata[15:8];
			end
		end
	end

	//==========================================================
	// Read channel
	//==========================================================
	always_comb begin
		case (araddr)
			`REG_CONFIG: rd_value = {16'h0, cfg.brd, cfg.tate, 3'b000, cfg.pcb};
			`REG_DIP:    rd_value = {16'h0, cfg.dsw2, cfg.dsw1};
			`REG_WORDS:  rd_value = {words.dsw_sp85, words.dsw_m68k, words.p2, words.p1};
			`REG_ROTARY: rd_value = {4'h0, rotary2, 4'h0, rotary1};
			default:     rd_value = 32'h0;
		endcase
	end

	always_ff @(posedge clk_72) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			arready <= arvalid & ~rvalid & ~arready;
			if (rd_hs)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	// Data is captured at acceptance and held while rvalid waits
	always_ff @(posedge clk_72) begin
		if (rd_hs)
			rdata <= rd_value;
	end

endmodule

`default_nettype wire

// ==== hdl/rotary_tracker.sv ====
//==========================================================
// Twelve-position rotary joystick tracker
// Rotates a one-hot ring one step per rising request
//==========================================================

`default_nettype none

`include "arcade_ctrl_params.svh"

module rotary_tracker import arcade_ctrl_pkg::*; (
	input  logic        clk_72,
	input  logic        reset,
	input  logic        cw,
	input  logic        ccw,
	output rotary_pos_t position
);

	logic cw_last;
	logic ccw_last;
	logic cw_rise;
	logic ccw_rise;

	assign cw_rise  = cw & ~cw_last;
	assign ccw_rise = ccw & ~ccw_last;

	always_ff @(posedge clk_72) begin
		if (reset) begin
			cw_last  <= 1'b0;
			ccw_last <= 1'b0;
			position <= `ROTARY_RESET;
		end else begin
			cw_last  <= cw;
			ccw_last <= ccw;
			// Counter-clockwise has priority on a tie
			if (ccw_rise)
				position <= {position[10:0], position[11]};
			else if (cw_rise)
				position <= {position[0], position[11:1]};
		end
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# Exit status is 0 only when the pass message is printed.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f filelist.f --top-module arcade_ctrl_tb -o sim_arcade_ctrl
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

# Let assertion errors accumulate so the testbench reports them itself
output=$(./obj_dir/sim_arcade_ctrl +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^Simulation passed$"; then
	exit 0
fi
echo "Pass message not found"
exit 1

// ==== tests/arcade_ctrl_sva.sv ====
//==========================================================
// Concurrent checks on the register slave
// AXI4-Lite handshake rules and one-hot rotary positions
// Attached to every ctrl_regs_axil through bind
//==========================================================

`default_nettype none

module arcade_ctrl_sva import arcade_ctrl_pkg::*; (
	input logic        clk_72,
	input logic        reset,
	input logic        awready,
	input logic        wready,
	input logic        bvalid,
	input logic        bready,
	input logic        arready,
	input logic        rvalid,
	input logic        rready,
	input logic [31:0] rdata,
	input rotary_pos_t rotary1,
	input rotary_pos_t rotary2
);

	timeunit 1ns;
	timeprecision 1ps;

	// Failed assertions so far, watched by the testbench
	int fail_count = 0;

	// Address and data are only taken with no write response outstanding
	aw_while_idle: assert property (@(posedge clk_72) disable iff (reset)
		awready || wready |-> !bvalid)
	else begin
		fail_count = fail_count + 1;
		$error("awready or wready raised while bvalid was high");
	end

	// A read is only accepted with no read data pending
	ar_while_idle: assert property (@(posedge clk_72) disable iff (reset)
		arready |-> !rvalid)
	else begin
		fail_count = fail_count + 1;
		$error("arready raised while rvalid was high");
	end

	b_held: assert property (@(posedge clk_72) disable iff (reset)
		bvalid && !bready |=> bvalid)
	else begin
		fail_count = fail_count + 1;
		$error("bvalid dropped before bready");
	end

	// Read data must not move while the host holds off
	r_held: assert property (@(posedge clk_72) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata))
	else begin
		fail_count = fail_count + 1;
		$error("rvalid or rdata changed before rready");
	end

	rotary_one_hot: assert property (@(posedge clk_72) disable iff (reset)
		$onehot(rotary1) && $onehot(rotary2))
	else begin
		fail_count = fail_count + 1;
		$error("rotary ring lost its single set bit");
	end

endmodule

bind ctrl_regs_axil arcade_ctrl_sva sva_i (
	.clk_72  (clk_72),
	.reset   (reset),
	.awready (awready),
	.wready  (wready),
	.bvalid  (bvalid),
	.bready  (bready),
	.arready (arready),
	.rvalid  (rvalid),
	.rready  (rready),
	.rdata   (rdata),
	.rotary1 (rotary1),
	.rotary2 (rotary2)
);

`default_nettype wire

// ==== tests/arcade_ctrl_tb.sv ====
//==========================================================
// Testbench for the player-control front end
// Drives players, service and AXI4-Lite host traffic, and
// compares read-back words and rings with its own models
//==========================================================

`default_nettype none

`include "arcade_ctrl_params.svh"

module arcade_ctrl_tb import arcade_ctrl_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD_NS = 10;
	localparam int N_WR = 12;
	localparam int N_STD = 24;
	localparam int N_GM = 24;
	localparam int N_SWEEP = 13;
	localparam int N_PULSE = 16;
	localparam int N_BP = 10;
	// Each planned operation fits in this many cycles
	localparam int OP_CYCLES = 80;
	localparam int NUM_OPS = 4 + N_WR + 3 + N_STD + 1 + N_GM + 1
		+ 2 * (4 * N_SWEEP + N_PULSE) + N_BP;

	logic                    clk_72;
	logic                    reset;
	player_raw_t             player1;
	player_raw_t             player2;
	service_t                service;
	logic [`CTRL_ADDR_W-1:0] awaddr;
	logic                    awvalid;
	logic                    awready;
	logic [31:0]             wdata;
	logic [3:0]              wstrb;
	logic                    wvalid;
	logic                    wready;
	logic [1:0]              bresp;
	logic                    bvalid;
	logic                    bready;
	logic [`CTRL_ADDR_W-1:0] araddr;
	logic                    arvalid;
	logic                    arready;
	logic [31:0]             rdata;
	logic [1:0]              rresp;
	logic                    rvalid;
	logic                    rready;

	int seed = 32'h3ae7_6543;

	// Models of the inputs, registers and rings
	player_raw_t cur1;
	player_raw_t cur2;
	service_t    cur_svc;
	logic [31:0] cfg_reg;
	logic [31:0] dip_reg;
	rotary_pos_t ring1;
	rotary_pos_t ring2;

	event compare_req;
	event compare_done;

	tb_clock_gen clock_i (
		.clk_72 (clk_72),
		.reset  (reset)
	);

	arcade_ctrl_top dut_i (
		.clk_72  (clk_72),
		.reset   (reset),
		.player1 (player1),
		.player2 (player2),
		.service (service),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready)
	);

	//==========================================================
	// Reference models
	//==========================================================
	function automatic logic [31:0] next_rand();
		return $random(seed);
	endfunction

	function automatic ctrl_cfg_t model_cfg();
		ctrl_cfg_t c;
		c.pcb  = cfg_reg[3:0];
		c.tate = cfg_reg[7];
		c.brd  = cfg_reg[15:8];
		c.dsw1 = dip_reg[7:0];
		c.dsw2 = dip_reg[15:8];
		return c;
	endfunction

	function automatic ctrl_words_t expected_words(input player_raw_t a, input player_raw_t b,
			input service_t s, input ctrl_cfg_t c);
		ctrl_words_t w;
		logic [7:0]  dip_low;
		dip_low    = {c.dsw1[7:2], ~s.test, ~s.service};
		w.dsw_sp85 = c.dsw2;
		if (c.pcb == `PCB_GOLDMEDL) begin
			// Player 1 is side a, player 2 side b, active high
			w.p1       = {a.start, b.start, b.fire[1], a.fire[1],
				b.fire[2], b.fire[0], a.fire[2], a.fire[0]};
			w.p2       = 8'h00;
			w.dsw_m68k = ~dip_low;
		end else begin
			w.p1       = ~{a.start, a.fire, a.right, a.left, a.down, a.up};
			w.p2       = ~{b.start, b.fire, b.right, b.left, b.down, b.up};
			w.dsw_m68k = dip_low;
		end
		return w;
	endfunction

	function automatic logic [31:0] expected_reg(input logic [3:0] addr);
		case (addr)
			`REG_CONFIG: return cfg_reg;
			`REG_DIP:    return dip_reg;
			`REG_WORDS:  return expected_words(cur1, cur2, cur_svc, model_cfg());
			`REG_ROTARY: return {4'h0, ring2, 4'h0, ring1};
			default:     return 32'h0;
		endcase
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
			input logic [3:0] strb, input logic [7:0] low_mask);
		logic [31:0] r;
		r = old;
		if (strb[0])
			r[7:0] = data[7:0] & low_mask;
		if (strb[1])
			r[15:8] = data[15:8];
		return r;
	endfunction

	function automatic logic cw_level(input player_raw_t p);
		return p.rotary_cw_btn | p.alt_right | p.alt_up;
	endfunction

	function automatic logic ccw_level(input player_raw_t p);
		return p.rotary_ccw_btn | p.alt_left | p.alt_down;
	endfunction

	// Clockwise moves toward bit 0, counter-clockwise wins a tie
	function automatic rotary_pos_t ring_step(input rotary_pos_t r, input logic cw_up,
			input logic ccw_up);
		if (ccw_up)
			return {r[10:0], r[11]};
		if (cw_up)
			return {r[0], r[11:1]};
		return r;
	endfunction

	//==========================================================
	// Checks and host tasks
	//==========================================================
	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("mismatch at time %0t: %s got 32'h%08h expected 32'h%08h",
				$time, name, got, exp));
	endtask

	task automatic host_write(input logic [3:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		int n;
		int delay;
		@(posedge clk_72);
		awaddr  <= addr;
		wdata   <= data;
		wstrb   <= strb;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		n = 0;
		do begin
			@(posedge clk_72);
			n++;
			if (n > 50)
				abort_run("AXI write address and data were never accepted");
		end while (!(awready && wready));
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		delay = int'(next_rand() & 32'h3);
		repeat (delay) @(posedge clk_72);
		bready <= 1'b1;
		n = 0;
		do begin
			@(posedge clk_72);
			n++;
			if (n > 50)
				abort_run("AXI write response never arrived");
		end while (!(bvalid && bready));
		compare_value("bresp", 32'(bresp), 32'h0);
		bready <= 1'b0;
	endtask

	task automatic host_read(input logic [3:0] addr, input logic [31:0] hold_mask,
			output logic [31:0] data);
		int          n;
		int          hold;
		logic [31:0] first;
		@(posedge clk_72);
		araddr  <= addr;
		arvalid <= 1'b1;
		n = 0;
		do begin
			@(posedge clk_72);
			n++;
			if (n > 50)
				abort_run("AXI read address was never accepted");
		end while (!arready);
		arvalid <= 1'b0;
		n = 0;
		do begin
			@(posedge clk_72);
			n++;
			if (n > 50)
				abort_run("AXI read data never became valid");
		end while (!rvalid);
		first = rdata;
		hold = int'(next_rand() & hold_mask);
		repeat (hold) begin
			@(posedge clk_72);
			compare_value("rvalid while held", 32'(rvalid), 32'h1);
			compare_value("rdata while held", rdata, first);
		end
		rready <= 1'b1;
		do
			@(posedge clk_72);
		while (!(rvalid && rready));
		compare_value("rresp", 32'(rresp), 32'h0);
		data = rdata;
		rready <= 1'b0;
	endtask

	task automatic read_and_check(input logic [3:0] addr, input string name,
			input logic [31:0] hold_mask);
		logic [31:0] got;
		host_read(addr, hold_mask, got);
		compare_value(name, got, expected_reg(addr));
	endtask

	task automatic sync_compare();
		-> compare_req;
		@(compare_done);
	endtask

	// Drives new levels and advances the ring models on rising requests
	task automatic apply_inputs(input player_raw_t n1, input player_raw_t n2,
			input service_t ns);
		@(posedge clk_72);
		player1 <= n1;
		player2 <= n2;
		service <= ns;
		ring1 = ring_step(ring1, cw_level(n1) & ~cw_level(cur1), ccw_level(n1) & ~ccw_level(cur1));
		ring2 = ring_step(ring2, cw_level(n2) & ~cw_level(cur2), ccw_level(n2) & ~ccw_level(cur2));
		cur1    = n1;
		cur2    = n2;
		cur_svc = ns;
		sync_compare();
	endtask

	task automatic pulse(input int player, input int src, input int hold);
		player_raw_t r;
		r = '0;
		case (src)
			0:       r.rotary_cw_btn = 1'b1;
			1:       r.alt_right = 1'b1;
			2:       r.alt_up = 1'b1;
			3:       r.rotary_ccw_btn = 1'b1;
			4:       r.alt_left = 1'b1;
			default: r.alt_down = 1'b1;
		endcase
		if (player == 1)
			apply_inputs(r, '0, cur_svc);
		else
			apply_inputs('0, r, cur_svc);
		repeat (hold) @(posedge clk_72);
		apply_inputs('0, '0, cur_svc);
	endtask

	//==========================================================
	// Comparing process and watchdog
	//==========================================================
	initial begin
		forever begin
			@(compare_req);
			repeat (3) @(posedge clk_72);
			read_and_check(`REG_WORDS, "REG_WORDS", 32'h1);
			read_and_check(`REG_ROTARY, "REG_ROTARY", 32'h1);
			-> compare_done;
		end
	end

	// A failed bound assertion ends the run at the next edge
	always @(posedge clk_72) begin
		if (dut_i.regs_i.sva_i.fail_count != 0)
			abort_run("a bound assertion on the register slave failed");
	end

	initial begin
		#(NUM_OPS * OP_CYCLES * CLK_PERIOD_NS);
		abort_run("watchdog expired before the tests finished");
	end

	//==========================================================
	// Stimulus
	//==========================================================
	initial begin
		logic [31:0] rnd;
		logic [31:0] data;
		logic [3:0]  addr;
		int          n_fail;
		player1 <= '0;
		player2 <= '0;
		service <= '0;
		awaddr  <= '0;
		awvalid <= 1'b0;
		wdata   <= '0;
		wstrb   <= '0;
		wvalid  <= 1'b0;
		bready  <= 1'b0;
		araddr  <= '0;
		arvalid <= 1'b0;
		rready  <= 1'b0;
		cur1    = '0;
		cur2    = '0;
		cur_svc = '0;
		cfg_reg = '0;
		dip_reg = '0;
		ring1   = `ROTARY_RESET;
		ring2   = `ROTARY_RESET;
		while (reset !== 1'b0)
			@(posedge clk_72);

		// State after reset
		read_and_check(`REG_CONFIG, "REG_CONFIG after reset", 32'h3);
		read_and_check(`REG_DIP, "REG_DIP after reset", 32'h3);
		read_and_check(`REG_ROTARY, "REG_ROTARY after reset", 32'h3);
		sync_compare();

		// Strobed writes, read-only offsets included
		for (int i = 0; i < N_WR; i++) begin
			rnd  = next_rand();
			addr = {rnd[1:0], 2'b00};
			data = next_rand();
			host_write(addr, data, rnd[7:4]);
			if (addr == `REG_CONFIG)
				cfg_reg = merge_bytes(cfg_reg, data, rnd[7:4], 8'h8F);
			else if (addr == `REG_DIP)
				dip_reg = merge_bytes(dip_reg, data, rnd[7:4], 8'hFF);
			read_and_check(addr, "register after write", 32'h3);
			sync_compare();
		end

		// Standard layout
		data = next_rand();
		if (data[3:0] == `PCB_GOLDMEDL)
			data[3:0] = 4'h0;
		host_write(`REG_CONFIG, data, 4'b0011);
		cfg_reg = merge_bytes(cfg_reg, data, 4'b0011, 8'h8F);
		data = next_rand();
		host_write(`REG_DIP, data, 4'b0011);
		dip_reg = merge_bytes(dip_reg, data, 4'b0011, 8'hFF);
		for (int i = 0; i < N_STD; i++) begin
			rnd = next_rand();
			apply_inputs(rnd[14:0], rnd[30:16], {rnd[31], rnd[15]});
		end

		// Gold-medal layout
		data = {28'h0, `PCB_GOLDMEDL};
		host_write(`REG_CONFIG, data, 4'b0001);
		cfg_reg = merge_bytes(cfg_reg, data, 4'b0001, 8'h8F);
		for (int i = 0; i < N_GM; i++) begin
			rnd = next_rand();
			apply_inputs(rnd[14:0], rnd[30:16], {rnd[31], rnd[15]});
		end

		// Rotary sweeps past the wrap point, then random held pulses
		apply_inputs('0, '0, '0);
		for (int i = 0; i < N_SWEEP; i++) begin
			pulse(1, i % 3, 0);
			pulse(2, 3 + i % 3, 0);
		end
		for (int i = 0; i < N_SWEEP; i++) begin
			pulse(1, 3 + i % 3, 1);
			pulse(2, i % 3, 1);
		end
		for (int i = 0; i < N_PULSE; i++) begin
			rnd = next_rand();
			pulse(1 + int'(rnd[0]), int'(rnd[15:8] % 8'd6), int'(rnd[5:4]));
		end

		// Reads with long rready back-pressure
		for (int i = 0; i < N_BP; i++) begin
			rnd = next_rand();
			read_and_check({rnd[1:0], 2'b00}, "read under back-pressure", 32'hF);
		end

		n_fail = dut_i.regs_i.sva_i.fail_count;
		if (n_fail == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			abort_run($sformatf("%0d assertion failures were reported", n_fail));
		end
	end

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
//==========================================================
// Clock and reset source for the testbench
// clk_72 has a 10 ns period, reset is held for 10 cycles
//==========================================================

`default_nettype none

module tb_clock_gen (
	output logic clk_72,
	output logic reset
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk_72 = 1'b0;
		forever #5 clk_72 = ~clk_72;
	end

	// Released on a rising edge like every other input
	initial begin
		reset = 1'b1;
		repeat (10) @(posedge clk_72);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire
